/* cc_macros.svh */
// sizes fixed for a class of seven 4-bit scores; changing them needs a new sorting network
`ifndef CC_MACROS_SVH
`define CC_MACROS_SVH

// ------------------------------------------------
// class and score sizes
// ------------------------------------------------
`define CC_NUM_STUDENTS 7    // students per class
`define CC_SCORE_W      4    // raw score bits
`define CC_ID_W         3    // enough for ids 0..6

// ------------------------------------------------
// derived widths
// ------------------------------------------------
// key is the raw score plus one extension bit
`define CC_KEY_W        5
// translated score holds 15 * 4 and -8 / 1
`define CC_WIDE_W       8
// threshold reaches -18 in signed mode
`define CC_THR_W        6

`endif

/* cc_pkg.sv */
// shared types for the class grader; every width suits exactly seven 4-bit scores
`default_nettype none

`include "cc_macros.svh"

package cc_pkg;

  // ------------------------------------------------
  // per-student values
  // ------------------------------------------------
  typedef logic [`CC_SCORE_W-1:0]       raw_score_t;   // as it arrives on the port
  typedef logic [`CC_ID_W-1:0]          student_id_t;
  typedef logic signed [`CC_KEY_W-1:0]  score_key_t;   // sign or zero extended score

  // id rides along with its key through the network
  typedef struct packed {
    student_id_t id;
    score_key_t  key;
  } tagged_entry_t;

  typedef tagged_entry_t [`CC_NUM_STUDENTS-1:0] entry_array_t;
  typedef student_id_t   [`CC_NUM_STUDENTS-1:0] id_array_t;   // index 0 is rank one

  // ------------------------------------------------
  // grading values
  // ------------------------------------------------
  typedef logic signed [`CC_WIDE_W-1:0] wide_score_t;  // score after gain
  typedef wide_score_t [`CC_NUM_STUDENTS-1:0] wide_array_t;
  typedef logic signed [`CC_THR_W-1:0]  threshold_t;
  typedef logic [2:0]                   gain_t;        // a + 1, range 1..4
  typedef logic [2:0]                   count_t;       // 0..7 students

endpackage

`default_nettype wire

/* student_if.sv */
// roster bundle for one class; all signals are combinational and there is no handshake
`timescale 1ns/1ps
`default_nettype none

interface student_if import cc_pkg::*; ();

  entry_array_t entries;     // id and key per student, in id order
  logic [1:0]   alpha;       // gain is alpha + 1
  logic [2:0]   beta;        // extra threshold offset
  wide_array_t  translated;  // scores after gain, in id order

  // top level builds the roster
  modport top (
    output entries, alpha, beta
  );

  modport translator (
    input  entries, alpha,
    output translated
  );

  modport sorter (
    input entries
  );

  // threshold needs the raw keys and both offsets
  modport counter (
    input entries, alpha, beta, translated
  );

endinterface

`default_nettype wire

/* compare_exchange.sv */
// one sorting cell; key order first and lower id first on ties, in either direction
`timescale 1ns/1ps
`default_nettype none

module compare_exchange import cc_pkg::*; (
  input  tagged_entry_t entry_a,
  input  tagged_entry_t entry_b,
  input  logic          descending,   // high puts the larger key first
  output tagged_entry_t first,
  output tagged_entry_t second
);

  score_key_t key_a;
  score_key_t key_b;
  logic       key_wrong;   // keys differ in the wrong direction
  logic       id_wrong;    // equal keys and a has the larger id
  logic       swap;

  assign key_a = entry_a.key;
  assign key_b = entry_b.key;

  always_comb begin
    if (descending) begin
      key_wrong = key_a < key_b;   // signed compare
    end else begin
      key_wrong = key_a > key_b;
    end
    id_wrong = (key_a == key_b) && (entry_a.id > entry_b.id);
    swap     = key_wrong || id_wrong;

    if (swap) begin
      first  = entry_b;
      second = entry_a;
    end else begin
      first  = entry_a;
      second = entry_b;
    end

    // pair leaves in rank order, lower id first on equal keys
    assert ((descending ? (first.key >= second.key) : (first.key <= second.key))
            && !((first.key == second.key) && (first.id > second.id)))
      else $error("compare_exchange output pair is out of order");
  end

endmodule

`default_nettype wire

/* score_sorter.sv */
// fixed 18-cell network for exactly seven entries; ids come out in rank order
`timescale 1ns/1ps
`default_nettype none

module score_sorter import cc_pkg::*; (
  student_if.sorter roster,
  input  logic      descending,   // sort direction for every cell
  output id_array_t ranked_ids    // position 0 is first ranked
);

  tagged_entry_t cx_first  [18];  // lower output of each cell
  tagged_entry_t cx_second [18];

  // ------------------------------------------------
  // four-entry odd-even sort over ids 0..3
  // ------------------------------------------------
  compare_exchange u_cx00 (.entry_a(roster.entries[0]), .entry_b(roster.entries[1]),
    .descending(descending), .first(cx_first[0]), .second(cx_second[0]));
  compare_exchange u_cx01 (.entry_a(roster.entries[2]), .entry_b(roster.entries[3]),
    .descending(descending), .first(cx_first[1]), .second(cx_second[1]));
  compare_exchange u_cx03 (.entry_a(cx_second[0]), .entry_b(cx_first[1]),
    .descending(descending), .first(cx_first[3]), .second(cx_second[3]));
  compare_exchange u_cx05 (.entry_a(cx_first[0]), .entry_b(cx_first[3]),
    .descending(descending), .first(cx_first[5]), .second(cx_second[5]));
  compare_exchange u_cx06 (.entry_a(cx_second[3]), .entry_b(cx_second[1]),
    .descending(descending), .first(cx_first[6]), .second(cx_second[6]));
  compare_exchange u_cx08 (.entry_a(cx_second[5]), .entry_b(cx_first[6]),
    .descending(descending), .first(cx_first[8]), .second(cx_second[8]));

  // ------------------------------------------------
  // three-entry sort over ids 4..6
  // ------------------------------------------------
  compare_exchange u_cx02 (.entry_a(roster.entries[4]), .entry_b(roster.entries[5]),
    .descending(descending), .first(cx_first[2]), .second(cx_second[2]));
  compare_exchange u_cx04 (.entry_a(cx_second[2]), .entry_b(roster.entries[6]),
    .descending(descending), .first(cx_first[4]), .second(cx_second[4]));
  compare_exchange u_cx07 (.entry_a(cx_first[2]), .entry_b(cx_first[4]),
    .descending(descending), .first(cx_first[7]), .second(cx_second[7]));

  // ------------------------------------------------
  // merge of the sorted four and sorted three
  // ------------------------------------------------
  compare_exchange u_cx09 (.entry_a(cx_first[5]), .entry_b(cx_first[7]),     // both heads
    .descending(descending), .first(cx_first[9]), .second(cx_second[9]));
  compare_exchange u_cx10 (.entry_a(cx_second[6]), .entry_b(cx_second[4]),   // both tails
    .descending(descending), .first(cx_first[10]), .second(cx_second[10]));
  compare_exchange u_cx11 (.entry_a(cx_second[9]), .entry_b(cx_first[8]),
    .descending(descending), .first(cx_first[11]), .second(cx_second[11]));
  compare_exchange u_cx12 (.entry_a(cx_second[7]), .entry_b(cx_first[10]),
    .descending(descending), .first(cx_first[12]), .second(cx_second[12]));
  compare_exchange u_cx13 (.entry_a(cx_second[11]), .entry_b(cx_first[12]),
    .descending(descending), .first(cx_first[13]), .second(cx_second[13]));
  compare_exchange u_cx14 (.entry_a(cx_second[8]), .entry_b(cx_second[12]),
    .descending(descending), .first(cx_first[14]), .second(cx_second[14]));
  compare_exchange u_cx15 (.entry_a(cx_first[11]), .entry_b(cx_first[13]),
    .descending(descending), .first(cx_first[15]), .second(cx_second[15]));
  compare_exchange u_cx16 (.entry_a(cx_second[13]), .entry_b(cx_first[14]),
    .descending(descending), .first(cx_first[16]), .second(cx_second[16]));
  compare_exchange u_cx17 (.entry_a(cx_second[15]), .entry_b(cx_first[16]),  // middle pair
    .descending(descending), .first(cx_first[17]), .second(cx_second[17]));

  // rank taps, outer ranks settle early
  assign ranked_ids[0] = cx_first[9].id;
  assign ranked_ids[1] = cx_first[15].id;
  assign ranked_ids[2] = cx_first[17].id;
  assign ranked_ids[3] = cx_second[17].id;
  assign ranked_ids[4] = cx_second[16].id;
  assign ranked_ids[5] = cx_second[14].id;
  assign ranked_ids[6] = cx_second[10].id;

endmodule

`default_nettype wire

/* score_translator.sv */
// gain of alpha + 1 per student; negative keys divide toward zero and the rest multiply
`timescale 1ns/1ps
`default_nettype none

`include "cc_macros.svh"

module score_translator import cc_pkg::*; (
  student_if.translator roster
);

  gain_t       gain;      // 1..4
  wide_array_t result;

  // ------------------------------------------------
  // gain from alpha
  // ------------------------------------------------
  assign gain = gain_t'({1'b0, roster.alpha}) + gain_t'(1);

  // ------------------------------------------------
  // per-student translation
  // ------------------------------------------------
  always_comb begin
    score_key_t          key;
    logic signed [3:0]   gain_s;   // signed copy so the divide stays signed
    wide_score_t         quot;
    wide_score_t         prod;

    gain_s = $signed({1'b0, gain});
    for (int i = 0; i < `CC_NUM_STUDENTS; i++) begin
      key  = roster.entries[i].key;
      quot = key / gain_s;         // truncates toward zero
      prod = key * gain_s;         // at most 15 * 4
      if (key < 0) begin
        result[i] = quot;
      end else begin
        result[i] = prod;
      end

      // negative keys shrink toward zero, the rest never drop below the key
      assert (key < 0 ? (result[i] >= key && result[i] <= 0) : (result[i] >= key))
        else $error("score_translator lane %0d out of range for key %0d", i, key);
    end
  end

  assign roster.translated = result;

endmodule

`default_nettype wire

/* pass_counter.sv */
// threshold is class mean toward zero minus alpha and beta; 6-bit so signed mode cannot wrap
`timescale 1ns/1ps
`default_nettype none

`include "cc_macros.svh"

module pass_counter import cc_pkg::*; (
  student_if.counter roster,
  input  logic       count_below,   // high counts below threshold
  output count_t     pass_count
);

  logic signed [`CC_WIDE_W-1:0] class_sum;   // -56..105
  threshold_t                   mean;        // -8..15
  threshold_t                   threshold;   // -18..15

  // ------------------------------------------------
  // class mean and threshold
  // ------------------------------------------------
  always_comb begin
    score_key_t key;

    class_sum = '0;
    for (int i = 0; i < `CC_NUM_STUDENTS; i++) begin
      key       = roster.entries[i].key;
      class_sum = class_sum + key;   // sign extends in signed mode
    end
    mean      = threshold_t'(class_sum / 8'sd7);
    threshold = mean - threshold_t'({1'b0, roster.alpha})
                     - threshold_t'({1'b0, roster.beta});
  end

  // ------------------------------------------------
  // vote per student
  // ------------------------------------------------
  always_comb begin
    wide_score_t t;
    logic        below;
    logic        hit;

    pass_count = '0;
    for (int i = 0; i < `CC_NUM_STUDENTS; i++) begin
      t     = roster.translated[i];
      below = t < wide_score_t'(threshold);   // both signed
      hit   = count_below ? below : !below;
      pass_count = pass_count + count_t'(hit);
    end
  end

endmodule

`default_nettype wire

/* score_ranker.sv */
// purely combinational grader for seven students; opt[0] signed, opt[1] descending, opt[2] below
`timescale 1ns/1ps
`default_nettype none

`include "cc_macros.svh"

module score_ranker import cc_pkg::*; (
  input  raw_score_t  in_s0,
  input  raw_score_t  in_s1,
  input  raw_score_t  in_s2,
  input  raw_score_t  in_s3,
  input  raw_score_t  in_s4,
  input  raw_score_t  in_s5,
  input  raw_score_t  in_s6,
  input  logic [2:0]  opt,
  input  logic [1:0]  a,
  input  logic [2:0]  b,
  output student_id_t s_id0,   // first ranked
  output student_id_t s_id1,
  output student_id_t s_id2,
  output student_id_t s_id3,
  output student_id_t s_id4,
  output student_id_t s_id5,
  output student_id_t s_id6,   // last ranked
  output count_t      out
);

  student_if roster ();

  raw_score_t   scores [`CC_NUM_STUDENTS];
  entry_array_t entries;
  id_array_t    ranked_ids;

  // ------------------------------------------------
  // tagged entries from the raw ports
  // ------------------------------------------------
  assign scores = '{in_s0, in_s1, in_s2, in_s3, in_s4, in_s5, in_s6};

  always_comb begin
    for (int i = 0; i < `CC_NUM_STUDENTS; i++) begin
      entries[i].id  = student_id_t'(i);   // id fixed by port position
      entries[i].key = {opt[0] & scores[i][`CC_SCORE_W-1], scores[i]};
    end
  end

  assign roster.entries = entries;
  assign roster.alpha   = a;
  assign roster.beta    = b;

  // ------------------------------------------------
  // sort, translate, count
  // ------------------------------------------------
  score_sorter u_sorter (
    .roster     (roster),
    .descending (opt[1]),
    .ranked_ids (ranked_ids)
  );

  score_translator u_translator (
    .roster (roster)
  );

  pass_counter u_counter (
    .roster      (roster),
    .count_below (opt[2]),
    .pass_count  (out)
  );

  assign s_id0 = ranked_ids[0];
  assign s_id1 = ranked_ids[1];
  assign s_id2 = ranked_ids[2];
  assign s_id3 = ranked_ids[3];
  assign s_id4 = ranked_ids[4];
  assign s_id5 = ranked_ids[5];
  assign s_id6 = ranked_ids[6];

endmodule

`default_nettype wire

/* tb_score_ranker_tests.svh */
// directed tests, included inside tb_score_ranker; scores packed as 28'h with s6 leftmost
`ifndef TB_SCORE_RANKER_TESTS_SVH
`define TB_SCORE_RANKER_TESTS_SVH

// --------------------------------------------------
// sorting
// --------------------------------------------------
task automatic unsigned_ascending_sort();
  run_vector("unsigned_ascending", 28'h3A51F07, 3'b000, 2'd0, 3'd0);   // all distinct
  run_vector("unsigned_ascending", 28'h5555555, 3'b000, 2'd1, 3'd2);   // all tied, id order
  run_vector("unsigned_ascending", 28'h2929292, 3'b000, 2'd2, 3'd5);
  run_vector("unsigned_ascending", 28'hF8E0C18, 3'b000, 2'd3, 3'd7);   // 8 twice, F on top
endtask

task automatic signed_descending_sort();
  run_vector("signed_descending", 28'h8F07A13, 3'b011, 2'd0, 3'd0);    // -8, -1, -6 mixed in
  run_vector("signed_descending", 28'hFFF0FFF, 3'b011, 2'd1, 3'd1);    // six -1 ties
  run_vector("signed_descending", 28'h7878787, 3'b011, 2'd2, 3'd3);    // extremes only
  run_vector("signed_descending", 28'hC3C3E33, 3'b011, 2'd3, 3'd6);
endtask

// --------------------------------------------------
// threshold sweeps over every a and b
// --------------------------------------------------
// mostly -8, mean -7, threshold down to -17
task automatic below_threshold_sweep();
  for (int ai = 0; ai < 4; ai++) begin
    for (int bi = 0; bi < 8; bi++) begin
      run_vector("count_below", 28'h8898A88, 3'b101, 2'(ai), 3'(bi));
      below_counts[ai * 8 + bi] = last_out;
    end
  end
endtask

task automatic at_or_above_sweep();
  int idx;

  for (int ai = 0; ai < 4; ai++) begin
    for (int bi = 0; bi < 8; bi++) begin
      idx = ai * 8 + bi;
      run_vector("count_at_or_above", 28'h8898A88, 3'b001, 2'(ai), 3'(bi));
      check_count++;   // both polarities cover the whole class
      assert (last_out + below_counts[idx] == 7) else begin
        error_count++;
        $display("Mismatch count_polarity_sum a=%0d b=%0d: expected 7, actual %0d",
                 ai, bi, last_out + below_counts[idx]);
      end
    end
  end
endtask

// --------------------------------------------------
// random vectors, all outputs against the model
// --------------------------------------------------
task automatic random_sweep();
  logic [27:0] scores;
  logic [2:0]  opt_v;
  logic [1:0]  a_v;
  logic [2:0]  b_v;

  for (int n = 0; n < 200; n++) begin
    scores = 28'($urandom());
    opt_v  = 3'($urandom());
    a_v    = 2'($urandom());
    b_v    = 3'($urandom());
    run_vector("random", scores, opt_v, a_v, b_v);
  end
endtask

`endif

/* tb_score_ranker.sv */
// drives the combinational DUT on the falling edge and checks at the rising edge; no DUT reset
`timescale 1ns/1ps
`default_nettype none

`include "cc_macros.svh"

module tb_score_ranker import cc_pkg::*; ();

  // --------------------------------------------------
  // run length and timing
  // --------------------------------------------------
  localparam int CLK_PERIOD    = 10;
  localparam int RESET_CYCLES  = 10;
  localparam int TOTAL_VECTORS = 4 + 4 + 32 + 32 + 200;   // sum of all five tests
  localparam int WATCHDOG_NS   = (RESET_CYCLES + TOTAL_VECTORS + 50) * CLK_PERIOD;
  localparam logic [31:0] SEED = 32'hddc14602;

  logic        clk;
  logic        reset;   // local only, holds off the tests

  // DUT ports
  raw_score_t  in_s0, in_s1, in_s2, in_s3, in_s4, in_s5, in_s6;
  logic [2:0]  opt;
  logic [1:0]  a;
  logic [2:0]  b;
  student_id_t s_id0, s_id1, s_id2, s_id3, s_id4, s_id5, s_id6;
  count_t      out;

  // stimulus and reference model state
  logic [27:0] stim_packed;          // s0 in the low nibble
  logic [2:0]  stim_opt;
  logic [1:0]  stim_a;
  logic [2:0]  stim_b;
  int          exp_ids [`CC_NUM_STUDENTS];
  int          exp_count;
  int          last_out;             // out of the latest vector
  int          below_counts [32];    // indexed by a * 8 + b
  int          vector_count = 0;
  int          check_count  = 0;
  int          error_count  = 0;

  score_ranker u_score_ranker (
    .in_s0 (in_s0), .in_s1 (in_s1), .in_s2 (in_s2), .in_s3 (in_s3),
    .in_s4 (in_s4), .in_s5 (in_s5), .in_s6 (in_s6),
    .opt   (opt),
    .a     (a),
    .b     (b),
    .s_id0 (s_id0), .s_id1 (s_id1), .s_id2 (s_id2), .s_id3 (s_id3),
    .s_id4 (s_id4), .s_id5 (s_id5), .s_id6 (s_id6),
    .out   (out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // local reset for the start-up cycles
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

  // --------------------------------------------------
  // reference model, straight from the grading rules
  // --------------------------------------------------
  // raw nibble to its numeric score
  function automatic int key_of(input logic [3:0] score, input logic signed_mode);
    if (signed_mode && score[3]) begin
      return int'(score) - 16;   // two's complement
    end
    return int'(score);
  endfunction

  // strict order only, so ties keep the lower id first
  function automatic bit ranks_before(input int key_x, input int key_y, input bit desc);
    return desc ? (key_x > key_y) : (key_x < key_y);
  endfunction

  task automatic compute_expected();
    int keys [`CC_NUM_STUDENTS];
    int sum;
    int gain;
    int thr;
    int t;
    int tmp;
    int j;

    sum  = 0;
    gain = int'(stim_a) + 1;
    for (int i = 0; i < `CC_NUM_STUDENTS; i++) begin
      keys[i]    = key_of(stim_packed[4*i +: 4], stim_opt[0]);
      sum        = sum + keys[i];
      exp_ids[i] = i;   // start in id order
    end
    // insertion sort, stable
    for (int i = 1; i < `CC_NUM_STUDENTS; i++) begin
      j = i;
      while (j > 0 && ranks_before(keys[exp_ids[j]], keys[exp_ids[j-1]], stim_opt[1])) begin
        tmp          = exp_ids[j];
        exp_ids[j]   = exp_ids[j-1];
        exp_ids[j-1] = tmp;
        j--;
      end
    end
    thr = sum / 7 - int'(stim_a) - int'(stim_b);   // int divide truncates toward zero
    exp_count = 0;
    for (int i = 0; i < `CC_NUM_STUDENTS; i++) begin
      t = (keys[i] < 0) ? keys[i] / gain : keys[i] * gain;
      if ((t < thr) == stim_opt[2]) begin
        exp_count++;   // below when opt[2] high, at or above when low
      end
    end
  endtask

  // --------------------------------------------------
  // one vector, falling edge in and rising edge check
  // --------------------------------------------------
  task automatic run_vector(input string name, input logic [27:0] packed_scores,
                            input logic [2:0] opt_v, input logic [1:0] a_v,
                            input logic [2:0] b_v);
    student_id_t got_ids [`CC_NUM_STUDENTS];

    stim_packed = packed_scores;
    stim_opt    = opt_v;
    stim_a      = a_v;
    stim_b      = b_v;
    compute_expected();
    @(negedge clk);
    in_s0 = packed_scores[3:0];
    in_s1 = packed_scores[7:4];
    in_s2 = packed_scores[11:8];
    in_s3 = packed_scores[15:12];
    in_s4 = packed_scores[19:16];
    in_s5 = packed_scores[23:20];
    in_s6 = packed_scores[27:24];
    opt   = opt_v;
    a     = a_v;
    b     = b_v;
    @(posedge clk);   // outputs long settled
    got_ids = '{s_id0, s_id1, s_id2, s_id3, s_id4, s_id5, s_id6};
    for (int k = 0; k < `CC_NUM_STUDENTS; k++) begin
      check_count++;
      assert (int'(got_ids[k]) == exp_ids[k]) else begin
        error_count++;
        $display("Mismatch %s s_id%0d scores=%h opt=%b: expected %0d, actual %0d",
                 name, k, packed_scores, opt_v, exp_ids[k], got_ids[k]);
      end
    end
    check_count++;
    assert (int'(out) == exp_count) else begin
      error_count++;
      $display("Mismatch %s out scores=%h opt=%b a=%0d b=%0d: expected %0d, actual %0d",
               name, packed_scores, opt_v, a_v, b_v, exp_count, out);
    end
    last_out = int'(out);
    vector_count++;
  endtask

  `include "tb_score_ranker_tests.svh"

  // --------------------------------------------------
  // main sequence and watchdog
  // --------------------------------------------------
  initial begin
    void'($urandom(SEED));   // one seed for the whole run
    {in_s0, in_s1, in_s2, in_s3, in_s4, in_s5, in_s6} = '0;
    opt   = '0;
    a     = '0;
    b     = '0;
    wait (reset == 1'b0);

    unsigned_ascending_sort();
    signed_descending_sort();
    below_threshold_sweep();
    at_or_above_sweep();
    random_sweep();

    check_count++;
    assert (vector_count == TOTAL_VECTORS) else begin
      error_count++;
      $display("vector count is off: ran %0d of %0d planned", vector_count, TOTAL_VECTORS);
    end
    $display("summary: %0d vectors, %0d checks, %0d errors",
             vector_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns with %0d vectors done", WATCHDOG_NS, vector_count);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
cc_pkg.sv
student_if.sv
compare_exchange.sv
score_sorter.sv
score_translator.sv
pass_counter.sv
score_ranker.sv
tb_score_ranker.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_score_ranker \
  -f flist.f -o tb_score_ranker_sim || { echo "build failed"; exit 1; }
sim_out=$(./obj_dir/tb_score_ranker_sim)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "Test OK" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
